// ==== compile.f ====
+incdir+include
rtl/rp_pkg.sv
rtl/rp_reg_if.sv
rtl/rpFunctionDecode.sv
rtl/rpOffsetReg.sv
rtl/rpAddressRegs.sv
rtl/rpDriveStatus.sv
rtl/rpDrive.sv
verification/rpDriveChecker.sv
verification/rpDriveTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the RP drive testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   -f compile.f --top-module rpDriveTb

simStatus=0
./obj_dir/VrpDriveTb > sim.log 2>&1 || simStatus=$?
cat sim.log

# A crash or the fail message both count as failure
if [ "$simStatus" -ne 0 ] || grep -q "Verification failed" sim.log; then
   echo "Simulation reported failure, see sim.log"
   exit 1
fi
echo "Simulation finished without failure"

// ==== verification/rpDriveTb.sv ====
////////////////////////////////////////
// RP drive register file testbench
// Reset, a stimulus table and the loop
// that applies it to the DUT
////////////////////////////////////////

`timescale 1ns/100ps

`include "rp_defs.svh"

module rpDriveTb;

   // Run limits in clock cycles
   localparam int maxRunCycles = 2000;
   localparam int readyTimeout = 4 * `RP_SEEK_CYCLES;

   // One table row
   typedef struct packed {
      logic [4:0]  sel;
      logic [35:0] data;
      logic        write;
      logic        pulseClr;
      logic        syncReady;
      logic [7:0]  waitCycles;
      logic [15:0] expRd;
      logic        expAta;
   } stimEntry_t;

   logic        clk;
   logic        rst;
   logic        clr;
   logic [4:0]  regSel;
   logic [35:0] wrData;
   logic        regWrite;
   logic [15:0] rdData;
   logic        ata;

   // Expected values handed to the checker
   logic        checkEn;
   logic [15:0] expRd;
   logic        expAta;
   int          checkCount;
   int          errorCount;
   int          timeoutCount;

   stimEntry_t  stimTable[$];

   rpDrive dut_i (
      .clk(clk), .rst(rst), .clr(clr), .regSel(regSel), .wrData(wrData),
      .regWrite(regWrite), .rdData(rdData), .ata(ata)
   );

   rpDriveChecker checker_i (
      .clk(clk), .rst(rst), .regSel(regSel), .rdData(rdData), .ata(ata),
      .checkEn(checkEn), .expRd(expRd), .expAta(expAta),
      .checkCount(checkCount), .errorCount(errorCount)
   );

   // 100 ns clock
   initial clk = 1'b0;
   always #50 clk = ~clk;

   ////////////////////////////////////////
   // Table building
   ////////////////////////////////////////

   // Status word from its three live bits
   function automatic logic [15:0] dsWord(input logic ataBit, input logic dryBit,
                                          input logic omBit);
      logic [15:0] w;
      w             = '0;
      w[`RP_DS_ATA] = ataBit;
      w[`RP_DS_DRY] = dryBit;
      w[`RP_DS_OM]  = omBit;
      return w;
   endfunction

   function automatic void addEntry(input logic [4:0] sel, input logic [35:0] data,
                                    input logic write, input logic pulseClr,
                                    input logic syncReady, input int waitCycles,
                                    input logic [15:0] expRdVal, input logic expAtaVal);
      stimEntry_t e;
      e.sel        = sel;
      e.data       = data;
      e.write      = write;
      e.pulseClr   = pulseClr;
      e.syncReady  = syncReady;
      e.waitCycles = 8'(waitCycles);
      e.expRd      = expRdVal;
      e.expAta     = expAtaVal;
      stimTable.push_back(e);
   endfunction

   function automatic void buildTable();
      logic [35:0] rnd;
      int          k;
      //       sel          data            wr clr syn wait             expRd            ata
      // Reset state, DS shows only dry
      addEntry(`RP_REG_CS1, 36'h0,          0, 0, 0, 0,               16'h0000,        0);
      addEntry(`RP_REG_DS,  36'h0,          0, 0, 0, 0,               dsWord(0, 1, 0), 0);
      addEntry(`RP_REG_DA,  36'h0,          0, 0, 0, 0,               16'h0000,        0);
      addEntry(`RP_REG_DC,  36'h0,          0, 0, 0, 0,               16'h0000,        0);
      addEntry(`RP_REG_OF,  36'h0,          0, 0, 0, 0,               16'h0000,        0);
      // All ones, only the defined fields stick
      addEntry(`RP_REG_OF,  36'hF_FFFF_FFFF, 1, 0, 1, 0,              16'h1CFF,        0);
      addEntry(`RP_REG_DS,  36'h0,          0, 0, 0, 0,               dsWord(0, 1, 1), 0);
      addEntry(`RP_REG_DA,  36'hF_FFFF_FFFF, 1, 0, 1, 0,              16'h1F3F,        0);
      addEntry(`RP_REG_DC,  36'hF_FFFF_FFFF, 1, 0, 1, 0,              16'h03FF,        0);
      addEntry(`RP_REG_DA,  36'h8_0000_CA95, 1, 0, 1, 0,              16'h0A15,        0);
      // Random cylinders keep bits 9:0
      for (k = 0; k < 3; k++)
      begin
         rnd = {4'($urandom()), 32'($urandom())};
         addEntry(`RP_REG_DC, rnd, 1, 0, 1, 0, {6'b0, rnd[9:0]}, 0);
      end
      addEntry(`RP_REG_DC,  36'h0_0000_F2A5, 1, 0, 1, 0,              16'h02A5,        0);
      // CENTER, GO reads back while positioning
      addEntry(`RP_REG_CS1, 36'h0F,         1, 0, 1, 0,               16'h000F,        0);
      addEntry(`RP_REG_OF,  36'h0,          0, 0, 1, 0,               16'h1C00,        1);
      addEntry(`RP_REG_DS,  36'h0,          0, 0, 0, 0,               dsWord(1, 1, 0), 1);
      addEntry(`RP_REG_DC,  36'h0,          0, 0, 0, 0,               16'h02A5,        1);
      // DRVCLR drops attention on its pulse
      addEntry(`RP_REG_CS1, 36'h09,         1, 0, 1, 1,               16'h0008,        0);
      addEntry(`RP_REG_OF,  36'h1C85,       1, 0, 1, 0,               16'h1C85,        0);
      // PRESET clears format bits and address
      addEntry(`RP_REG_CS1, 36'h11,         1, 0, 1, 1,               16'h0010,        0);
      addEntry(`RP_REG_OF,  36'h0,          0, 0, 0, 0,               16'h0085,        0);
      addEntry(`RP_REG_DA,  36'h0,          0, 0, 0, 0,               16'h0000,        0);
      addEntry(`RP_REG_DC,  36'h0,          0, 0, 0, 0,               16'h0000,        0);
      // Bus init clears offset and address
      addEntry(`RP_REG_DA,  36'h8_0000_CA95, 1, 0, 1, 0,              16'h0A15,        0);
      addEntry(`RP_REG_OF,  36'h0,          0, 1, 0, 0,               16'h0000,        0);
      addEntry(`RP_REG_DA,  36'h0,          0, 0, 0, 0,               16'h0000,        0);
      // SEEK, dry low for exactly the seek time
      addEntry(`RP_REG_OF,  36'h1C03,       1, 0, 1, 0,               16'h1C03,        0);
      addEntry(`RP_REG_DS,  36'h0,          0, 0, 0, 0,               dsWord(0, 1, 1), 0);
      addEntry(`RP_REG_CS1, 36'h05,         1, 0, 1, 0,               16'h0005,        0);
      addEntry(`RP_REG_DS,  36'h0,          0, 0, 0, 0,               dsWord(0, 0, 1), 0);
      // Busy drive drops this write
      addEntry(`RP_REG_OF,  36'hFFFF,       1, 0, 0, 0,               16'h1C03,        0);
      // Last busy cycle, then dry and ata together
      addEntry(`RP_REG_DS,  36'h0,          0, 0, 0, `RP_SEEK_CYCLES - 5, dsWord(0, 0, 1), 0);
      addEntry(`RP_REG_DS,  36'h0,          0, 0, 0, 0,               dsWord(1, 1, 1), 1);
      addEntry(`RP_REG_CS1, 36'h0,          0, 0, 0, 0,               16'h0004,        1);
      // DRVCLR again, offset mode tracks OFS
      addEntry(`RP_REG_CS1, 36'h09,         1, 0, 1, 1,               16'h0008,        0);
      addEntry(`RP_REG_DS,  36'h0,          0, 0, 0, 0,               dsWord(0, 1, 1), 0);
      addEntry(`RP_REG_OF,  36'h1000,       1, 0, 1, 0,               16'h1000,        0);
      addEntry(`RP_REG_DS,  36'h0,          0, 0, 0, 0,               dsWord(0, 1, 0), 0);
      addEntry(`RP_REG_OF,  36'h0140,       1, 0, 1, 0,               16'h0040,        0);
      addEntry(`RP_REG_DS,  36'h0,          0, 0, 0, 0,               dsWord(0, 1, 1), 0);
      // RECAL ends in attention too
      addEntry(`RP_REG_CS1, 36'h07,         1, 0, 1, 0,               16'h0007,        0);
      addEntry(`RP_REG_DS,  36'h0,          0, 0, 1, 0,               dsWord(1, 1, 1), 1);
   endfunction

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // Poll DS until the drive is ready
   task automatic waitDriveReady();
      int   n;
      logic seen;
      seen     = 1'b0;
      regSel   = `RP_REG_DS;
      regWrite = 1'b0;
      for (n = 0; n < readyTimeout && !seen; n++)
      begin
         @(negedge clk);
         seen = rdData[`RP_DS_DRY];
      end
      if (!seen)
      begin
         timeoutCount++;
         $display("TIMEOUT at %0t: drive ready did not return within %0d cycles",
                  $time, readyTimeout);
      end
   endtask

   // Called on a falling edge, returns on one
   task automatic applyEntry(input stimEntry_t e);
      int n;
      if (e.syncReady)
         waitDriveReady();
      regSel   = e.sel;
      wrData   = e.data;
      regWrite = e.write;
      clr      = e.pulseClr;
      if (e.write || e.pulseClr)
      begin
         @(negedge clk);
         regWrite = 1'b0;
         clr      = 1'b0;
         wrData   = '0;
      end
      for (n = 0; n < e.waitCycles; n++)
         @(negedge clk);
      // Checker compares at the next rising edge
      expRd   = e.expRd;
      expAta  = e.expAta;
      checkEn = 1'b1;
      @(negedge clk);
      checkEn = 1'b0;
   endtask

   task automatic reportResult();
      if (checkCount != stimTable.size())
         $display("Only %0d of %0d table checks were made", checkCount, stimTable.size());
      $display("Closing counts: %0d checks, %0d errors, %0d timeouts",
               checkCount, errorCount, timeoutCount);
      if (errorCount == 0 && timeoutCount == 0 && checkCount == stimTable.size())
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   endtask

   initial
   begin
      int i;
      rst          = 1'b1;
      clr          = 1'b0;
      regSel       = '0;
      wrData       = '0;
      regWrite     = 1'b0;
      checkEn      = 1'b0;
      expRd        = '0;
      expAta       = 1'b0;
      timeoutCount = 0;
      void'($urandom(32'hf71c_5e5c));
      buildTable();
      // Two clocks of reset
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (i = 0; i < stimTable.size(); i++)
         applyEntry(stimTable[i]);
      reportResult();
   end

   // Whole-run limit
   initial
   begin
      int cycles;
      for (cycles = 0; cycles < maxRunCycles; cycles++)
         @(posedge clk);
      $display("TIMEOUT: run did not finish within %0d clock cycles", maxRunCycles);
      $display("Verification failed");
      $finish;
   end

endmodule

// ==== verification/rpDriveChecker.sv ====
////////////////////////////////////////
// RP drive checker
// Compares read data and attention with
// the values the testbench expects
////////////////////////////////////////

`timescale 1ns/100ps

module rpDriveChecker (
   input  logic        clk,
   input  logic        rst,
   input  logic [4:0]  regSel,
   input  logic [15:0] rdData,
   input  logic        ata,
   input  logic        checkEn,
   input  logic [15:0] expRd,
   input  logic        expAta,
   output int          checkCount,
   output int          errorCount
);

   int checks = 0;
   int errors = 0;

   assign checkCount = checks;
   assign errorCount = errors;

   ////////////////////////////////////////
   // Compare on the rising edge
   ////////////////////////////////////////

   // Inputs settled since the falling edge
   always @(posedge clk)
   begin
      if (!rst)
      begin
         // Attention must be a clean level
         if ($isunknown(ata))
         begin
            errors = errors + 1;
            $display("Attention output is unknown at time %0t", $time);
         end
         if (checkEn)
         begin
            checks = checks + 1;
            // Read mux against the table value
            if (rdData !== expRd)
            begin
               errors = errors + 1;
               $display("CHECK FAILED time=%0t signal=rdData sel=%02o expected=%04h actual=%04h",
                        $time, regSel, expRd, rdData);
            end
            // Attention level
            if (ata !== expAta)
            begin
               errors = errors + 1;
               $display("CHECK FAILED time=%0t signal=ata sel=%02o expected=%0b actual=%0b",
                        $time, regSel, expAta, ata);
            end
         end
      end
   end

endmodule

// ==== rtl/rpDrive.sv ====
////////////////////////////////////////
// RP drive register file
// Write strobe decode, blocks, read mux
////////////////////////////////////////

`timescale 1ns/100ps

`include "rp_defs.svh"

module rpDrive (
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  logic [4:0]  regSel,
   input  logic [35:0] wrData,
   input  logic        regWrite,
   output logic [15:0] rdData,
   output logic        ata
);

   rpRegBus regBus ();

   logic            center;
   logic            preset;
   logic            drvClr;
   logic            seekDone;
   logic            offsetMode;
   logic [15:0]     ofReg;
   logic [15:0]     daReg;
   logic [15:0]     dcReg;
   logic [15:0]     dsReg;
   rp_pkg::rpFunc_t cs1Func;

   ////////////////////////////////////////
   // Write bus
   ////////////////////////////////////////

   assign regBus.data     = wrData;
   assign regBus.dataWord = wrData[15:0];

   // One strobe per selected register
   assign regBus.wrCs1 = regWrite & (regSel == `RP_REG_CS1);
   assign regBus.wrDa  = regWrite & (regSel == `RP_REG_DA);
   assign regBus.wrDc  = regWrite & (regSel == `RP_REG_DC);
   assign regBus.wrOf  = regWrite & (regSel == `RP_REG_OF);

   // Last function written, for CS1 readback
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         cs1Func <= rp_pkg::NOP;
      else if (regBus.wrCs1 & regBus.dry)
         cs1Func <= regBus.dataWord.cs1.func;
   end

   ////////////////////////////////////////
   // Register blocks
   ////////////////////////////////////////

   rpFunctionDecode decode_i (
      .clk(clk), .rst(rst), .clr(clr), .bus(regBus.producer),
      .center(center), .preset(preset), .drvClr(drvClr), .seekDone(seekDone)
   );

   rpOffsetReg offset_i (
      .clk(clk), .rst(rst), .clr(clr), .center(center), .preset(preset),
      .bus(regBus.consumer), .ofReg(ofReg), .offsetMode(offsetMode)
   );

   rpAddressRegs address_i (
      .clk(clk), .rst(rst), .clr(clr), .preset(preset),
      .bus(regBus.consumer), .daReg(daReg), .dcReg(dcReg)
   );

   rpDriveStatus status_i (
      .clk(clk), .rst(rst), .drvClr(drvClr), .seekDone(seekDone),
      .offsetMode(offsetMode), .bus(regBus.consumer), .dsReg(dsReg), .ata(ata)
   );

   ////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////

   always_comb
   begin
      rdData = '0;
      case (regSel)
         `RP_REG_CS1:
         begin
            rdData[`RP_CS1_FUN_HI:`RP_CS1_FUN_LO] = cs1Func;
            // GO stays up while the drive is positioning
            rdData[`RP_CS1_GO] = ~regBus.dry;
         end
         `RP_REG_DS: rdData = dsReg;
         `RP_REG_DA: rdData = daReg;
         `RP_REG_DC: rdData = dcReg;
         `RP_REG_OF: rdData = ofReg;
         default:    rdData = '0;
      endcase
   end

endmodule

// ==== rtl/rpDriveStatus.sv ====
////////////////////////////////////////
// RPDS drive status
// Attention, drive ready, offset mode
////////////////////////////////////////

`timescale 1ns/100ps

`include "rp_defs.svh"

module rpDriveStatus (
   input  logic        clk,
   input  logic        rst,
   input  logic        drvClr,
   input  logic        seekDone,
   input  logic        offsetMode,
   rpRegBus.consumer   bus,
   output logic [15:0] dsReg,
   output logic        ata
);

   ////////////////////////////////////////
   // Attention
   ////////////////////////////////////////

   // Set by end of positioning
   // Cleared by drive clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ata <= 1'b0;
      else if (drvClr)
         ata <= 1'b0;
      else if (seekDone)
         ata <= 1'b1;
   end

   ////////////////////////////////////////
   // Status word
   ////////////////////////////////////////

   always_comb
   begin
      dsReg             = '0;
      dsReg[`RP_DS_ATA] = ata;
      dsReg[`RP_DS_DRY] = bus.dry;
      dsReg[`RP_DS_OM]  = offsetMode;
   end

   // Timer end and drive clear come from exclusive states
   assert property (@(posedge clk) disable iff (rst)
      !(seekDone && drvClr))
      else $error("rpDriveStatus: attention set and clear together");

endmodule

// ==== rtl/rpAddressRegs.sv ====
////////////////////////////////////////
// RPDA and RPDC desired address
// Track, sector and cylinder
////////////////////////////////////////

`timescale 1ns/100ps

`include "rp_defs.svh"

module rpAddressRegs (
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  logic        preset,
   rpRegBus.consumer   bus,
   output logic [15:0] daReg,
   output logic [15:0] dcReg
);

   localparam int cylWidth = `RP_DC_CA_HI - `RP_DC_CA_LO + 1;

   logic                loadDa;
   logic                loadDc;
   logic [4:0]          track;
   logic [5:0]          sector;
   logic [cylWidth-1:0] cylinder;

   // Both gated by drive ready
   assign loadDa = bus.wrDa & bus.dry;
   assign loadDc = bus.wrDc & bus.dry;

   // Desired track and sector from the DA view
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         track  <= '0;
         sector <= '0;
      end
      else if (preset | clr)
      begin
         track  <= '0;
         sector <= '0;
      end
      else if (loadDa)
      begin
         track  <= bus.dataWord.da.track;
         sector <= bus.dataWord.da.sector;
      end
   end

   // Desired cylinder straight from the data bus
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         cylinder <= '0;
      else if (preset | clr)
         cylinder <= '0;
      else if (loadDc)
         cylinder <= bus.data[`RP_DC_CA_HI:`RP_DC_CA_LO];
   end

   // Register images
   always_comb
   begin
      daReg                             = '0;
      daReg[`RP_DA_TA_HI:`RP_DA_TA_LO]  = track;
      daReg[`RP_DA_SA_HI:`RP_DA_SA_LO]  = sector;
      dcReg                             = '0;
      dcReg[`RP_DC_CA_HI:`RP_DC_CA_LO]  = cylinder;
   end

endmodule

// ==== rtl/rpOffsetReg.sv ====
////////////////////////////////////////
// RPOF offset register
// Format, inhibit and head offset bits
////////////////////////////////////////

`timescale 1ns/100ps

`include "rp_defs.svh"

module rpOffsetReg (
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   input  logic        center,
   input  logic        preset,
   rpRegBus.consumer   bus,
   output logic [15:0] ofReg,
   output logic        offsetMode
);

   logic       load;
   logic       fmt22;
   logic       eci;
   logic       hci;
   logic       ofd;
   logic [6:0] ofs;

   // Writes ignored while positioning
   assign load = bus.wrOf & bus.dry;

   ////////////////////////////////////////
   // FMT22, ECI, HCI
   ////////////////////////////////////////

   // Stored only, cleared by preset
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         fmt22 <= 1'b0;
         eci   <= 1'b0;
         hci   <= 1'b0;
      end
      else if (preset)
      begin
         fmt22 <= 1'b0;
         eci   <= 1'b0;
         hci   <= 1'b0;
      end
      else if (load)
      begin
         fmt22 <= bus.dataWord.of.fmt22;
         eci   <= bus.dataWord.of.eci;
         hci   <= bus.dataWord.of.hci;
      end
   end

   ////////////////////////////////////////
   // OFD, OFS
   ////////////////////////////////////////

   // Head back on track after init or center
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ofd <= 1'b0;
         ofs <= '0;
      end
      else if (clr | center)
      begin
         ofd <= 1'b0;
         ofs <= '0;
      end
      else if (load)
      begin
         ofd <= bus.dataWord.of.ofd;
         ofs <= bus.dataWord.of.ofs;
      end
   end

   // Register image, spare bits zero
   always_comb
   begin
      ofReg                               = '0;
      ofReg[`RP_OF_FMT22]                 = fmt22;
      ofReg[`RP_OF_ECI]                   = eci;
      ofReg[`RP_OF_HCI]                   = hci;
      ofReg[`RP_OF_OFD]                   = ofd;
      ofReg[`RP_OF_OFS_HI:`RP_OF_OFS_LO]  = ofs;
   end

   // Any offset step means offset mode
   assign offsetMode = |ofs;

   // Busy drive must not take an offset write
   assert property (@(posedge clk) disable iff (rst)
      (bus.wrOf && !bus.dry && !clr && !center && !preset) |=> $stable(ofReg))
      else $error("rpOffsetReg: offset write landed while drive busy");

endmodule

// ==== rtl/rpFunctionDecode.sv ====
////////////////////////////////////////
// RP function decoder
// Turns GO writes into command pulses
// and times seeks against drive ready
////////////////////////////////////////

`timescale 1ns/100ps

`include "rp_defs.svh"

module rpFunctionDecode (
   input  logic      clk,
   input  logic      rst,
   input  logic      clr,
   rpRegBus.producer bus,
   output logic      center,
   output logic      preset,
   output logic      drvClr,
   output logic      seekDone
);

   localparam int cntWidth = $clog2(`RP_SEEK_CYCLES + 1);
   localparam logic [cntWidth-1:0] cntLoad = cntWidth'(`RP_SEEK_CYCLES - 1);

   logic                goWrite;
   logic                startPos;
   logic                busy;
   logic [cntWidth-1:0] count;

   // GO accepted only on a ready drive
   assign goWrite = bus.wrCs1 & bus.dataWord.cs1.go & bus.dry;

   // Positioning commands start the timer
   always_comb
   begin
      startPos = 1'b0;
      if (goWrite)
      begin
         case (bus.dataWord.cs1.func)
            rp_pkg::SEEK,
            rp_pkg::RECAL,
            rp_pkg::CENTER: startPos = 1'b1;
            default:        startPos = 1'b0;
         endcase
      end
   end

   ////////////////////////////////////////
   // Command pulses
   ////////////////////////////////////////

   // One clock after the GO write
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         center <= 1'b0;
         preset <= 1'b0;
         drvClr <= 1'b0;
      end
      else if (clr)
      begin
         center <= 1'b0;
         preset <= 1'b0;
         drvClr <= 1'b0;
      end
      else
      begin
         center <= goWrite && (bus.dataWord.cs1.func == rp_pkg::CENTER);
         preset <= goWrite && (bus.dataWord.cs1.func == rp_pkg::PRESET);
         drvClr <= goWrite && (bus.dataWord.cs1.func == rp_pkg::DRVCLR);
      end
   end

   ////////////////////////////////////////
   // Seek timer
   ////////////////////////////////////////

   // Busy for exactly RP_SEEK_CYCLES clocks
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busy  <= 1'b0;
         count <= '0;
      end
      else if (clr)
      begin
         busy  <= 1'b0;
         count <= '0;
      end
      else if (startPos)
      begin
         busy  <= 1'b1;
         count <= cntLoad;
      end
      else if (busy)
      begin
         if (count == '0)
            busy <= 1'b0;
         else
            count <= count - 1'b1;
      end
   end

   // Last busy cycle, attention sets as dry returns
   assign seekDone = busy & (count == '0) & ~clr;

   // Drive ready
   assign bus.dry = ~busy;

   // Only one command strobe per clock
   assert property (@(posedge clk) disable iff (rst)
      $onehot0({center, preset, drvClr, seekDone}))
      else $error("rpFunctionDecode: overlapping command pulses");

endmodule

// ==== rtl/rp_reg_if.sv ====
////////////////////////////////////////
// RP register write bus
// Write data, strobes and drive ready
////////////////////////////////////////

`timescale 1ns/100ps

interface rpRegBus;

   // Full 36-bit write data and its low half
   logic [35:0]      data;
   rp_pkg::rpWord_t  dataWord;

   // One-hot write strobes
   logic             wrCs1;
   logic             wrDa;
   logic             wrDc;
   logic             wrOf;

   // Drive ready from the function decoder
   logic             dry;

   // Top level side
   modport driver   (output data, dataWord, wrCs1, wrDa, wrDc, wrOf, input dry);

   // Function decoder owns drive ready
   modport producer (input data, dataWord, wrCs1, wrDa, wrDc, wrOf, output dry);

   // Register blocks
   modport consumer (input data, dataWord, wrCs1, wrDa, wrDc, wrOf, dry);

endinterface

// ==== rtl/rp_pkg.sv ====
////////////////////////////////////////
// RP drive types
// Function codes and the decoded views
// of the low register data word
////////////////////////////////////////

package rp_pkg;

   // RPCS1 function field, bits 5:1
   // Codes follow the RP04/RP06 set
   typedef enum logic [4:0] {
      NOP    = 5'o00,
      SEEK   = 5'o02,
      RECAL  = 5'o03,
      DRVCLR = 5'o04,
      CENTER = 5'o07,
      PRESET = 5'o10
   } rpFunc_t;

   // Control word layout
   typedef struct packed {
      logic [9:0] rsvd;
      rpFunc_t    func;
      logic       go;
   } rpCs1Word_t;

   // Offset word layout
   typedef struct packed {
      logic [2:0] rsvd1;
      logic       fmt22;
      logic       eci;
      logic       hci;
      logic [1:0] rsvd0;
      logic       ofd;
      logic [6:0] ofs;
   } rpOfWord_t;

   // Desired track/sector layout
   typedef struct packed {
      logic [2:0] rsvd1;
      logic [4:0] track;
      logic [1:0] rsvd0;
      logic [5:0] sector;
   } rpDaWord_t;

   // One write word, read per register select
   typedef union packed {
      rpCs1Word_t cs1;
      rpOfWord_t  of;
      rpDaWord_t  da;
   } rpWord_t;

endpackage

// ==== include/rp_defs.svh ====
////////////////////////////////////////
// RP drive register definitions
// Register select codes, field bit
// positions and seek timing
////////////////////////////////////////

`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

// Massbus register select codes
`define RP_REG_CS1     5'o00
`define RP_REG_DS      5'o01
`define RP_REG_DA      5'o05
`define RP_REG_OF      5'o11
`define RP_REG_DC      5'o12

// RPCS1 fields
`define RP_CS1_FUN_HI  5
`define RP_CS1_FUN_LO  1
`define RP_CS1_GO      0

// RPDA fields
`define RP_DA_TA_HI    12
`define RP_DA_TA_LO    8
`define RP_DA_SA_HI    5
`define RP_DA_SA_LO    0

// RPDC cylinder field
`define RP_DC_CA_HI    9
`define RP_DC_CA_LO    0

// RPOF fields
`define RP_OF_FMT22    12
`define RP_OF_ECI      11
`define RP_OF_HCI      10
`define RP_OF_OFD      7
`define RP_OF_OFS_HI   6
`define RP_OF_OFS_LO   0

// RPDS status bits
`define RP_DS_ATA      15
`define RP_DS_DRY      7
`define RP_DS_OM       0

// Positioning time in clocks
`define RP_SEEK_CYCLES 8

`endif
